/* Bender.yml */
package:
  name: nts_dispatcher

sources:
  - verilog/nts_dispatch_pkg.sv
  - verilog/nts_rx_aligner.sv
  - verilog/nts_frame_ram.sv
  - verilog/nts_buffer_ctrl.sv
  - verilog/nts_dispatch_regs.sv
  - verilog/nts_dispatcher.sv
  - target: test
    files:
      - tests/nts_dispatcher_tb.sv

/* flist.f */
verilog/nts_dispatch_pkg.sv
verilog/nts_rx_aligner.sv
verilog/nts_frame_ram.sv
verilog/nts_buffer_ctrl.sv
verilog/nts_dispatch_regs.sv
verilog/nts_dispatcher.sv
tests/nts_dispatcher_tb.sv

/* tests/nts_dispatcher_stimulus.txt */
# Commands: test <name> | frame <good|bad> <beats> <last mask> <base data> | quiet <cycles>
# read <beats> <last mask> <expected words> | apb <addr> <value> | counter <name>
test full_frame
frame good 4 ff 0123456789ab0000
read 4 ff 0123456789ab0000 0123456789ab0001 0123456789ab0002 0123456789ab0003
test partial_last
frame good 3 07 fedcba9876540000
read 3 07 fedcba9876540000 fedcba9876540001 5400020000000000
test bad_frame
frame bad 3 ff 00000000deadbeef
quiet 30
test back_to_back
frame good 2 ff aaaa000000000000
frame good 3 0f bbbb000000000000
read 2 ff aaaa000000000000 aaaa000000000001
read 3 0f bbbb000000000000 bbbb000000000001 0000000200000000
test overflow
frame good 20 ff 5555000000000000
quiet 40
test registers
apb 000 4e54532d
apb 001 44495350
apb 002 302e3032
apb 003 00000000
counter frames
counter good
counter bad
counter dispatched
counter error
counter bytes

/* tests/nts_dispatcher_tb.sv */
// Testbench for the NTS dispatcher; runs the command lines of the stimulus file against the DUT
module nts_dispatcher_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import nts_dispatch_pkg::*;

  localparam int    ADDR_WIDTH = 4;
  localparam int    DEPTH      = 2**ADDR_WIDTH;  // Words per frame buffer
  localparam int    CLK_PERIOD = 8;
  localparam string STIM_FILE  = "tests/nts_dispatcher_stimulus.txt";

  // Tallies kept in the order frames, good, bad, dispatched, error, received bytes
  localparam apb_addr_t COUNTER_MSB [6] = '{
    ADDR_FRAMES_MSB, ADDR_GOOD_MSB, ADDR_BAD_MSB,
    ADDR_DISPATCHED_MSB, ADDR_ERROR_MSB, ADDR_BYTES_RX_MSB
  };
  localparam apb_addr_t COUNTER_LSB [6] = '{
    ADDR_FRAMES_LSB, ADDR_GOOD_LSB, ADDR_BAD_LSB,
    ADDR_DISPATCHED_LSB, ADDR_ERROR_LSB, ADDR_BYTES_RX_LSB
  };
  string counter_names [6] = '{"frames", "good", "bad", "dispatched", "error", "bytes"};

  logic                  i_clk = 1'b0;
  logic                  i_areset;
  mac_rx_t               mac_rx;
  apb_req_t              apb;
  apb_data_t             prdata;
  logic                  pready;
  logic                  packet_available;
  logic [ADDR_WIDTH-1:0] dispatch_counter;
  byte_valid_t           dispatch_data_valid;
  logic                  fifo_empty;
  logic                  fifo_rd_start;
  logic                  fifo_rd_valid;
  word_t                 fifo_rd_data;
  logic                  packet_discard;

  counter_t tally [6];
  word_t    exp_words [32];  // Expected read-out of the current read command
  string    test_name;
  int       line_count;
  int       n_checks;
  int       n_errors;

  nts_dispatcher #(.ADDR_WIDTH(ADDR_WIDTH)) nts_dispatcher_i (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_mac_rx              (mac_rx),
    .i_apb                 (apb),
    .o_prdata              (prdata),
    .o_pready              (pready),
    .o_packet_available    (packet_available),
    .o_dispatch_counter    (dispatch_counter),
    .o_dispatch_data_valid (dispatch_data_valid),
    .o_fifo_empty          (fifo_empty),
    .i_fifo_rd_start       (fifo_rd_start),
    .o_fifo_rd_valid       (fifo_rd_valid),
    .o_fifo_rd_data        (fifo_rd_data),
    .i_packet_discard      (packet_discard)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic check_value(string what, logic [63:0] exp, logic [63:0] got);
    n_checks++;
    assert (got === exp)
    else
    begin
      n_errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, got);
    end
  endtask

  task automatic check_true(bit ok, string what);
    n_checks++;
    assert (ok)
    else
    begin
      n_errors++;
      $display("ERROR %s: %s", test_name, what);
    end
  endtask

  // Tokens read with %s sit right-aligned in the vector
  function automatic string text_of(logic [127:0] t);
    string s;
    s = "";
    for (int i = 15; i >= 0; i--)
    begin
      if (t[8*i +: 8] != 8'h00)
      begin
        s = $sformatf("%s%c", s, t[8*i +: 8]);
      end
    end
    return s;
  endfunction

  // --------------------------------------------------
  // MAC and read-out drivers
  // --------------------------------------------------
  task automatic send_frame(bit good, int n, byte_valid_t last_mask, word_t base);
    mac_rx_t beat;
    @(negedge i_clk);
    mac_rx = '0;  // Idle gap before the start beat
    for (int i = 0; i < n; i++)
    begin
      @(negedge i_clk);
      beat            = '0;
      beat.data_valid = (i == n - 1) ? last_mask : 8'hff;
      beat.data       = base + word_t'(i);
      beat.good_frame = good && (i == n - 1);
      beat.bad_frame  = !good && (i == n - 1);
      mac_rx          = beat;
    end
    @(negedge i_clk);
    mac_rx = '0;
    tally[0]++;
    if (good)
    begin
      tally[1]++;
    end
    else
    begin
      tally[2]++;
    end
    if (n > DEPTH)
    begin
      tally[4]++;
    end
    tally[5] += counter_t'(8 * (n - 1) + $countones(last_mask));
  endtask

  task automatic read_packet(int n, byte_valid_t last_mask);
    int waited;
    bit exp_valid;
    waited = 0;
    @(negedge i_clk);
    while (!packet_available && waited < 200)
    begin
      @(negedge i_clk);
      waited++;
    end
    if (!packet_available)
    begin
      check_true(1'b0, "no packet became available for read-out");
      return;
    end
    check_value("dispatch counter", n - 1, dispatch_counter);
    check_value("last beat mask", last_mask, dispatch_data_valid);
    fifo_rd_start = 1'b1;
    tally[3]++;
    // Words follow the accepted start after three cycles
    for (int k = 1; k <= n + 3; k++)
    begin
      @(negedge i_clk);
      fifo_rd_start = 1'b0;
      exp_valid     = (k >= 3) && (k <= n + 2);
      check_value($sformatf("read valid cycle %0d", k), exp_valid, fifo_rd_valid);
      if (exp_valid && fifo_rd_valid)
      begin
        check_value($sformatf("word %0d", k - 3), exp_words[k - 3], fifo_rd_data);
      end
      check_value($sformatf("fifo empty cycle %0d", k), k == n + 3, fifo_empty);
    end
    check_value("available before discard", 0, packet_available);
    packet_discard = 1'b1;
    @(negedge i_clk);
    packet_discard = 1'b0;
  endtask

  task automatic expect_quiet(int cycles);
    repeat (cycles)
    begin
      @(negedge i_clk);
      check_value("packet available", 0, packet_available);
    end
  endtask

  // --------------------------------------------------
  // APB access
  // --------------------------------------------------
  task automatic apb_read(apb_addr_t addr, output apb_data_t data);
    @(negedge i_clk);
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(negedge i_clk);
    apb.penable = 1'b1;
    #(CLK_PERIOD / 4);  // Sampled well before the next rising edge
    check_true(pready, "APB access phase without pready");
    data = prdata;
    @(negedge i_clk);
    apb = '0;
  endtask

  task automatic check_counter(string name);
    int        idx;
    apb_data_t hi;
    apb_data_t lo;
    idx = -1;
    for (int i = 0; i < 6; i++)
    begin
      if (counter_names[i] == name)
      begin
        idx = i;
      end
    end
    if (idx < 0)
    begin
      check_true(1'b0, {"unknown counter name ", name});
      return;
    end
    apb_read(COUNTER_MSB[idx], hi);  // Latches the low half
    check_value({name, " msb"}, tally[idx][63:32], hi);
    apb_read(COUNTER_LSB[idx], lo);
    check_value({name, " lsb"}, tally[idx][31:0], lo);
  endtask

  initial
  begin
    int               fd;
    int               rc;
    int               n;
    string            cmd;
    logic [127:0]     tok;
    logic [8*256-1:0] line_buf;
    word_t            v1;
    word_t            v2;
    apb_data_t        rd;
    i_areset       = 1'b1;
    mac_rx         = '0;
    apb            = '0;
    fifo_rd_start  = 1'b0;
    packet_discard = 1'b0;
    test_name      = "setup";
    line_count     = 0;
    n_checks       = 0;
    n_errors       = 0;
    for (int i = 0; i < 6; i++)
    begin
      tally[i] = '0;
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0)
    begin
      check_true(1'b0, "cannot open the stimulus file");
    end
    else
    begin
      while (!$feof(fd))
      begin
        rc = $fgets(line_buf, fd);
        if (rc > 0)
        begin
          line_count++;
        end
      end
      $fclose(fd);
      fd = $fopen(STIM_FILE, "r");
    end
    repeat (3) @(negedge i_clk);
    i_areset = 1'b0;
    if (fd != 0)
    begin
      while ($fscanf(fd, "%s", tok) == 1)
      begin
        cmd = text_of(tok);
        if (cmd.substr(0, 0) == "#")
        begin
          rc = $fgets(line_buf, fd);  // Skip the rest of a comment
        end
        else if (cmd == "test")
        begin
          rc        = $fscanf(fd, "%s", tok);
          test_name = text_of(tok);
        end
        else if (cmd == "frame")
        begin
          rc = $fscanf(fd, "%s %d %h %h", tok, n, v1, v2);
          send_frame(text_of(tok) == "good", n, byte_valid_t'(v1), v2);
        end
        else if (cmd == "read")
        begin
          rc = $fscanf(fd, "%d %h", n, v1);
          for (int i = 0; i < n; i++)
          begin
            rc = $fscanf(fd, "%h", exp_words[i]);
          end
          read_packet(n, byte_valid_t'(v1));
        end
        else if (cmd == "quiet")
        begin
          rc = $fscanf(fd, "%d", n);
          expect_quiet(n);
        end
        else if (cmd == "apb")
        begin
          rc = $fscanf(fd, "%h %h", v1, v2);
          apb_read(apb_addr_t'(v1), rd);
          check_value($sformatf("apb read %03h", v1[11:0]), v2, rd);
        end
        else if (cmd == "counter")
        begin
          rc = $fscanf(fd, "%s", tok);
          check_counter(text_of(tok));
        end
        else
        begin
          check_true(1'b0, {"unknown stimulus command ", cmd});
        end
      end
      $fclose(fd);
    end
    repeat (5) @(negedge i_clk);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
    begin
      $display("Test OK");
    end
    else
    begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog scaled by the length of the stimulus
  initial
  begin
    wait (line_count > 0);
    #((line_count * 40 + 1000) * CLK_PERIOD);
    $display("ERROR: watchdog expired before the stimulus was finished");
    $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* verilog/nts_buffer_ctrl.sv */
// Ping-pong controller for the two frame RAMs that stores received frames and streams one out
module nts_buffer_ctrl #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_dispatch_pkg::rx_beat_t     i_beat,
  input  logic                           i_fifo_rd_start,
  input  logic                           i_packet_discard,
  input  nts_dispatch_pkg::word_t        i_ram_rdata0,
  input  nts_dispatch_pkg::word_t        i_ram_rdata1,
  output logic [ADDR_WIDTH-1:0]          o_ram_addr0,
  output logic [ADDR_WIDTH-1:0]          o_ram_addr1,
  output logic                           o_ram_write0,
  output logic                           o_ram_write1,
  output nts_dispatch_pkg::word_t        o_ram_wdata0,
  output nts_dispatch_pkg::word_t        o_ram_wdata1,
  output logic                           o_packet_available,
  output logic [ADDR_WIDTH-1:0]          o_dispatch_counter,
  output nts_dispatch_pkg::byte_valid_t  o_dispatch_data_valid,
  output logic                           o_fifo_empty,
  output logic                           o_fifo_rd_valid,
  output nts_dispatch_pkg::word_t        o_fifo_rd_data,
  output nts_dispatch_pkg::disp_events_t o_events
);
  import nts_dispatch_pkg::*;

  buf_state_t            state_q [2];
  logic [ADDR_WIDTH-1:0] count_q [2];  // Address of last stored word
  byte_valid_t           valid_q [2];  // Mask of last beat
  logic                  cur_q;        // Buffer owned by the receiver
  logic                  rb;           // Buffer owned by the reader

  buf_state_t            rx_state_d;
  buf_state_t            rd_state_d;
  logic [ADDR_WIDTH-1:0] rx_count_d;
  byte_valid_t           rx_valid_d;
  logic                  cur_d;
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic                  ovf_pulse;

  logic [ADDR_WIDTH-1:0] raddr_q;
  logic [ADDR_WIDTH-1:0] raddr_d;
  logic                  issuing;
  logic                  start_ok;
  logic                  ram_valid_q;  // RAM output holds a wanted word
  logic                  rd_valid_q;
  logic                  empty_q;
  word_t                 rd_data_q;

  assign rb = ~cur_q;

  // ------------------------------------------------
  // Receive side
  // ------------------------------------------------
  always_comb
  begin
    rx_state_d = state_q[cur_q];
    rx_count_d = count_q[cur_q];
    rx_valid_d = valid_q[cur_q];
    cur_d      = cur_q;
    wr_en      = 1'b0;
    wr_addr    = '0;
    ovf_pulse  = 1'b0;
    case (state_q[cur_q])
      EMPTY:
        if (i_beat.sof && !i_beat.bad_frame)
        begin
          wr_en      = 1'b1;  // First word at address 0
          rx_count_d = '0;
          rx_valid_d = i_beat.good_frame ? i_beat.data_valid : '0;
          rx_state_d = i_beat.good_frame ? RECEIVED : HAS_DATA;
        end
      HAS_DATA:
        if (i_beat.bad_frame)
        begin
          rx_state_d = EMPTY;
          rx_count_d = '0;
        end
        else if (i_beat.data_valid != '0)
        begin
          if (&count_q[cur_q])
          begin
            ovf_pulse  = 1'b1;  // No room for another word
            rx_state_d = EMPTY;
            rx_count_d = '0;
          end
          else
          begin
            wr_en      = 1'b1;
            wr_addr    = count_q[cur_q] + 1'b1;
            rx_count_d = wr_addr;
            if (i_beat.good_frame)
            begin
              rx_valid_d = i_beat.data_valid;
              rx_state_d = RECEIVED;
            end
          end
        end
      RECEIVED:
        if (state_q[rb] == EMPTY)
        begin
          rx_state_d = OUT_READY;  // Hand over to the reader
          cur_d      = ~cur_q;
        end
      default: ;
    endcase
  end

  // ------------------------------------------------
  // Read-out side
  // ------------------------------------------------
  always_comb
  begin
    rd_state_d = state_q[rb];
    raddr_d    = raddr_q;
    start_ok   = 1'b0;
    if (i_packet_discard && state_q[rb] != EMPTY)
    begin
      rd_state_d = EMPTY;
    end
    else
    begin
      case (state_q[rb])
        OUT_READY:
          if (i_fifo_rd_start)
          begin
            start_ok   = 1'b1;
            rd_state_d = OUT_START;
            raddr_d    = '0;
          end
        OUT_START, OUT_DATA:
          if (raddr_q == count_q[rb])
          begin
            rd_state_d = OUT_LAST;
          end
          else
          begin
            rd_state_d = OUT_DATA;
            raddr_d    = raddr_q + 1'b1;
          end
        OUT_LAST: rd_state_d = OUT_DONE;  // Pipeline drains
        default: ;
      endcase
    end
  end

  assign issuing = (state_q[rb] == OUT_START) || (state_q[rb] == OUT_DATA);

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < 2; i++)
      begin
        state_q[i] <= EMPTY;
        count_q[i] <= '0;
        valid_q[i] <= '0;
      end
      cur_q       <= 1'b0;
      raddr_q     <= '0;
      ram_valid_q <= 1'b0;
      rd_valid_q  <= 1'b0;
      empty_q     <= 1'b0;
    end
    else
    begin
      state_q[cur_q] <= rx_state_d;
      count_q[cur_q] <= rx_count_d;
      valid_q[cur_q] <= rx_valid_d;
      state_q[rb]    <= rd_state_d;
      cur_q          <= cur_d;
      raddr_q        <= raddr_d;
      ram_valid_q    <= issuing && !i_packet_discard;
      rd_valid_q     <= ram_valid_q && !i_packet_discard;
      if (start_ok)
      begin
        empty_q <= 1'b0;
      end
      else if (state_q[rb] == OUT_DONE || i_packet_discard)
      begin
        empty_q <= 1'b1;  // Held until the next start
      end
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (ram_valid_q)
    begin
      rd_data_q <= rb ? i_ram_rdata1 : i_ram_rdata0;
    end
  end

  // Writer owns one RAM, reader addresses the other
  assign o_ram_write0 = wr_en && !cur_q;
  assign o_ram_write1 = wr_en && cur_q;
  assign o_ram_addr0  = o_ram_write0 ? wr_addr : raddr_q;
  assign o_ram_addr1  = o_ram_write1 ? wr_addr : raddr_q;
  assign o_ram_wdata0 = i_beat.data;
  assign o_ram_wdata1 = i_beat.data;

  assign o_packet_available    = state_q[rb] == OUT_READY;
  assign o_dispatch_counter    = count_q[rb];
  assign o_dispatch_data_valid = valid_q[rb];
  assign o_fifo_empty          = empty_q;
  assign o_fifo_rd_valid       = rd_valid_q;
  assign o_fifo_rd_data        = rd_data_q;
  assign o_events              = '{dispatched: start_ok, overflow: ovf_pulse};

  // Words only stream from a buffer that still holds a frame
  a_no_data_from_empty: assert property (@(posedge i_clk) disable iff (i_areset)
    o_fifo_rd_valid |-> state_q[rb] != EMPTY);

  // Receive states stay with the receiving buffer across swaps
  a_writer_state: assert property (@(posedge i_clk) disable iff (i_areset)
    state_q[cur_q] inside {EMPTY, HAS_DATA, RECEIVED});

endmodule

/* verilog/nts_dispatch_pkg.sv */
// Shared types, buffer states, register map and core identity for the NTS dispatcher; import where needed
package nts_dispatch_pkg;

  typedef logic [63:0] word_t;        // MAC and frame word
  typedef logic [7:0]  byte_valid_t;  // One bit per byte lane
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [63:0] counter_t;
  typedef logic [3:0]  byte_count_t;  // 0 to 8

  // Raw receive beat from the MAC
  typedef struct packed {
    byte_valid_t data_valid;
    word_t       data;
    logic        good_frame;
    logic        bad_frame;
  } mac_rx_t;

  // Beat after start detection and last word alignment
  typedef struct packed {
    logic        sof;
    byte_valid_t data_valid;
    word_t       data;
    logic        good_frame;
    logic        bad_frame;
    byte_count_t bytes;
  } rx_beat_t;

  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    logic dispatched;  // Read-out accepted
    logic overflow;    // Frame too long for buffer
  } disp_events_t;

  typedef enum logic [2:0] {
    EMPTY, HAS_DATA, RECEIVED, OUT_READY, OUT_START, OUT_DATA, OUT_LAST, OUT_DONE
  } buf_state_t;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam apb_addr_t ADDR_NAME0           = 12'h000;
  localparam apb_addr_t ADDR_NAME1           = 12'h001;
  localparam apb_addr_t ADDR_VERSION         = 12'h002;
  localparam apb_addr_t ADDR_BYTES_RX_MSB    = 12'h00a;
  localparam apb_addr_t ADDR_BYTES_RX_LSB    = 12'h00b;
  localparam apb_addr_t ADDR_FRAMES_MSB      = 12'h020;
  localparam apb_addr_t ADDR_FRAMES_LSB      = 12'h021;
  localparam apb_addr_t ADDR_GOOD_MSB        = 12'h022;
  localparam apb_addr_t ADDR_GOOD_LSB        = 12'h023;
  localparam apb_addr_t ADDR_BAD_MSB         = 12'h024;
  localparam apb_addr_t ADDR_BAD_LSB         = 12'h025;
  localparam apb_addr_t ADDR_DISPATCHED_MSB  = 12'h026;
  localparam apb_addr_t ADDR_DISPATCHED_LSB  = 12'h027;
  localparam apb_addr_t ADDR_ERROR_MSB       = 12'h028;
  localparam apb_addr_t ADDR_ERROR_LSB       = 12'h029;

  localparam logic [63:0] CORE_NAME    = 64'h4e54_532d_4449_5350;  // "NTS-DISP"
  localparam apb_data_t   CORE_VERSION = 32'h302e_3032;            // "0.02"

endpackage

/* verilog/nts_dispatch_regs.sv */
// APB register block with core identity and 64-bit event counters read as MSB then LSB snapshot
module nts_dispatch_regs (
  input  logic                           i_clk,
  input  logic                           i_areset,
  input  nts_dispatch_pkg::apb_req_t     i_apb,
  input  nts_dispatch_pkg::rx_beat_t     i_beat,
  input  nts_dispatch_pkg::disp_events_t i_events,
  output nts_dispatch_pkg::apb_data_t    o_prdata,
  output logic                           o_pready
);
  import nts_dispatch_pkg::*;

  localparam int NUM_COUNTERS = 6;

  // Counter order: frames, good, bad, dispatched, error, received bytes
  localparam apb_addr_t MSB_ADDR [NUM_COUNTERS] = '{
    ADDR_FRAMES_MSB, ADDR_GOOD_MSB, ADDR_BAD_MSB,
    ADDR_DISPATCHED_MSB, ADDR_ERROR_MSB, ADDR_BYTES_RX_MSB
  };
  localparam apb_addr_t LSB_ADDR [NUM_COUNTERS] = '{
    ADDR_FRAMES_LSB, ADDR_GOOD_LSB, ADDR_BAD_LSB,
    ADDR_DISPATCHED_LSB, ADDR_ERROR_LSB, ADDR_BYTES_RX_LSB
  };

  counter_t                count_q [NUM_COUNTERS];
  counter_t                step    [NUM_COUNTERS];
  apb_data_t               snap_q  [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] snap_en;
  logic                    rd_access;

  assign o_pready  = i_apb.psel && i_apb.penable;  // Zero wait states
  assign rd_access = o_pready && !i_apb.pwrite;

  always_comb
  begin
    step[0] = counter_t'(i_beat.sof);
    step[1] = counter_t'(i_beat.good_frame);
    step[2] = counter_t'(i_beat.bad_frame);
    step[3] = counter_t'(i_events.dispatched);
    step[4] = counter_t'(i_events.overflow);
    step[5] = counter_t'(i_beat.bytes);
  end

  // ------------------------------------------------
  // Read decode
  // ------------------------------------------------
  always_comb
  begin
    o_prdata = '0;  // Unmapped reads as zero
    snap_en  = '0;
    if (i_apb.psel && !i_apb.pwrite)
    begin
      case (i_apb.paddr)
        ADDR_NAME0:   o_prdata = CORE_NAME[63:32];
        ADDR_NAME1:   o_prdata = CORE_NAME[31:0];
        ADDR_VERSION: o_prdata = CORE_VERSION;
        default: ;
      endcase
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        if (i_apb.paddr == MSB_ADDR[i])
        begin
          o_prdata   = count_q[i][63:32];
          snap_en[i] = rd_access;  // Freeze low half with this read
        end
        if (i_apb.paddr == LSB_ADDR[i])
        begin
          o_prdata = snap_q[i];
        end
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        count_q[i] <= '0;
        snap_q[i]  <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < NUM_COUNTERS; i++)
      begin
        count_q[i] <= count_q[i] + step[i];
        if (snap_en[i])
        begin
          snap_q[i] <= count_q[i][31:0];
        end
      end
    end
  end

  a_apb_enable_needs_sel: assert property (@(posedge i_clk) disable iff (i_areset)
    i_apb.penable |-> i_apb.psel);

endmodule

/* verilog/nts_dispatcher.sv */
// NTS dispatcher top: MAC receive aligner, ping-pong frame buffers with read-out, APB registers
module nts_dispatcher #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                          i_clk,
  input  logic                          i_areset,
  input  nts_dispatch_pkg::mac_rx_t     i_mac_rx,
  input  nts_dispatch_pkg::apb_req_t    i_apb,
  output nts_dispatch_pkg::apb_data_t   o_prdata,
  output logic                          o_pready,
  output logic                          o_packet_available,
  output logic [ADDR_WIDTH-1:0]         o_dispatch_counter,
  output nts_dispatch_pkg::byte_valid_t o_dispatch_data_valid,
  output logic                          o_fifo_empty,
  input  logic                          i_fifo_rd_start,
  output logic                          o_fifo_rd_valid,
  output nts_dispatch_pkg::word_t       o_fifo_rd_data,
  input  logic                          i_packet_discard
);
  import nts_dispatch_pkg::*;

  rx_beat_t              beat;
  disp_events_t          events;
  logic [ADDR_WIDTH-1:0] ram_addr  [2];
  logic                  ram_write [2];
  word_t                 ram_wdata [2];
  word_t                 ram_rdata [2];

  nts_rx_aligner u_aligner (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_mac_rx (i_mac_rx),
    .o_beat   (beat)
  );

  nts_buffer_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_buffer_ctrl (
    .i_clk                 (i_clk),
    .i_areset              (i_areset),
    .i_beat                (beat),
    .i_fifo_rd_start       (i_fifo_rd_start),
    .i_packet_discard      (i_packet_discard),
    .i_ram_rdata0          (ram_rdata[0]),
    .i_ram_rdata1          (ram_rdata[1]),
    .o_ram_addr0           (ram_addr[0]),
    .o_ram_addr1           (ram_addr[1]),
    .o_ram_write0          (ram_write[0]),
    .o_ram_write1          (ram_write[1]),
    .o_ram_wdata0          (ram_wdata[0]),
    .o_ram_wdata1          (ram_wdata[1]),
    .o_packet_available    (o_packet_available),
    .o_dispatch_counter    (o_dispatch_counter),
    .o_dispatch_data_valid (o_dispatch_data_valid),
    .o_fifo_empty          (o_fifo_empty),
    .o_fifo_rd_valid       (o_fifo_rd_valid),
    .o_fifo_rd_data        (o_fifo_rd_data),
    .o_events              (events)
  );

  // Ping and pong buffers
  for (genvar g = 0; g < 2; g++)
  begin : g_ram
    nts_frame_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
      .i_clk   (i_clk),
      .i_addr  (ram_addr[g]),
      .i_write (ram_write[g]),
      .i_data  (ram_wdata[g]),
      .o_data  (ram_rdata[g])
    );
  end

  nts_dispatch_regs u_regs (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .i_apb    (i_apb),
    .i_beat   (beat),
    .i_events (events),
    .o_prdata (o_prdata),
    .o_pready (o_pready)
  );

endmodule

/* verilog/nts_frame_ram.sv */
// Single-port frame buffer RAM, one 64-bit word per address, read data one cycle after address
module nts_frame_ram #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                    i_clk,
  input  logic [ADDR_WIDTH-1:0]   i_addr,
  input  logic                    i_write,
  input  nts_dispatch_pkg::word_t i_data,
  output nts_dispatch_pkg::word_t o_data
);
  import nts_dispatch_pkg::*;

  word_t mem [2**ADDR_WIDTH];

  always_ff @(posedge i_clk)
  begin
    if (i_write)
    begin
      mem[i_addr] <= i_data;
    end
    o_data <= mem[i_addr];  // Old contents on a write cycle
  end

endmodule

/* verilog/nts_rx_aligner.sv */
// Receive front end: registers MAC beats, flags start of frame and left-aligns the last word
module nts_rx_aligner (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  nts_dispatch_pkg::mac_rx_t  i_mac_rx,
  output nts_dispatch_pkg::rx_beat_t o_beat
);
  import nts_dispatch_pkg::*;

  byte_valid_t prev_valid_q;
  logic        sof;
  word_t       aligned;
  byte_count_t bytes;

  // Idle gap followed by a full beat
  assign sof = (prev_valid_q == '0) && (i_mac_rx.data_valid == '1);

  // ------------------------------------------------
  // Last word alignment
  // ------------------------------------------------
  always_comb
  begin
    aligned = i_mac_rx.data;  // Odd masks pass as they are
    bytes   = '0;
    if (i_mac_rx.data_valid == '0)
    begin
      aligned = '0;
    end
    // Low-aligned masks of k bytes move to the top lanes
    for (int k = 1; k <= 8; k++)
    begin
      if (i_mac_rx.data_valid == byte_valid_t'(8'hff >> (8 - k)))
      begin
        bytes   = byte_count_t'(k);
        aligned = i_mac_rx.data << (8 * (8 - k));
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      prev_valid_q <= '1;  // Must not look like an idle gap
      o_beat       <= '0;
    end
    else
    begin
      prev_valid_q <= i_mac_rx.data_valid;
      o_beat       <= '{sof:        sof,
                        data_valid: i_mac_rx.data_valid,
                        data:       aligned,
                        good_frame: i_mac_rx.good_frame,
                        bad_frame:  i_mac_rx.bad_frame,
                        bytes:      bytes};
    end
  end

endmodule
